//--- common/mac_tx_pkg.sv
`default_nettype none

package mac_tx_pkg;

  ////////////////////////////////
  // Widths
  ////////////////////////////////
  typedef logic [63:0] xgmii_word_t;
  typedef logic [7:0]  xgmii_ctrl_t;
  typedef logic [7:0]  byte_keep_t;
  typedef logic [31:0] crc_t;
  typedef logic [47:0] mac_addr_t;
  typedef logic [15:0] eth_type_t;
  typedef logic [15:0] word_count_t;

  typedef enum logic [2:0] {
    IDLE,
    PREAMBLE,
    HEADER_A,
    HEADER_B,
    PAYLOAD,
    TAIL,
    GAP
  } builder_state_t;

  ////////////////////////////////
  // Control characters
  ////////////////////////////////
  localparam logic [7:0] XGMII_IDLE    = 8'h07;
  localparam logic [7:0] XGMII_START   = 8'hFB;
  localparam logic [7:0] XGMII_TERM    = 8'hFD;
  localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
  localparam logic [7:0] SFD_BYTE      = 8'hD5;

  // Reflected CRC-32 as used for the Ethernet FCS
  localparam crc_t CRC_INIT           = 32'hFFFF_FFFF;
  localparam crc_t CRC_POLY_REFLECTED = 32'hEDB8_8320;
  localparam crc_t CRC_XOROUT         = 32'hFFFF_FFFF;

  // Idle words the builder inserts after each frame
  localparam int GAP_WORDS = 2;

endpackage

`default_nettype wire

//--- crc/crc32_byte_lane.sv
`timescale 1ns/10ps
`default_nettype none

module crc32_byte_lane (
  input  mac_tx_pkg::crc_t i_crc,
  input  wire [7:0]        i_byte,
  input  wire              i_en,
  output mac_tx_pkg::crc_t o_crc
);
  import mac_tx_pkg::*;

  crc_t step;

  // Data enters LSB first, one shift per bit
  always_comb begin
    step = i_crc ^ {24'h000000, i_byte};
    for (int b = 0; b < 8; b++) begin
      if (step[0]) begin
        step = (step >> 1) ^ CRC_POLY_REFLECTED;
      end else begin
        step = step >> 1;
      end
    end
    o_crc = i_en ? step : i_crc;
  end

endmodule

`default_nettype wire

//--- crc/crc32_engine.sv
`timescale 1ns/10ps
`default_nettype none

module crc32_engine (
  input  wire                       i_clk,
  input  wire                       i_rst,
  input  mac_tx_pkg::xgmii_word_t   i_word,
  input  mac_tx_pkg::byte_keep_t    i_crc_keep,
  input  wire                       i_crc_first,
  output mac_tx_pkg::crc_t          o_crc,
  output logic                      o_crc_done
);
  import mac_tx_pkg::*;

  crc_t chain [9];
  crc_t crc_q;
  logic busy;

  assign chain[0] = i_crc_first ? CRC_INIT : crc_q;

  // Lane 0 takes the first byte on the wire, bits 63:56
  for (genvar g = 0; g < 8; g++) begin : g_lane
    crc32_byte_lane u_lane (
      .i_crc  (chain[g]),
      .i_byte (i_word[63-8*g -: 8]),
      .i_en   (i_crc_keep[7-g]),
      .o_crc  (chain[g+1])
    );
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      crc_q <= CRC_INIT;
      busy  <= 1'b0;
    end else begin
      busy <= (i_crc_keep != '0);
      if (i_crc_keep != '0) begin
        crc_q <= chain[8];
      end
    end
  end

  // The word after the last one never carries CRC lanes
  assign o_crc      = crc_q ^ CRC_XOROUT;
  assign o_crc_done = busy && (i_crc_keep == '0);

endmodule

`default_nettype wire

//--- design/ten_gig_mac_tx.sv
`timescale 1ns/10ps
`default_nettype none

module ten_gig_mac_tx #(
  parameter mac_tx_pkg::mac_addr_t P_SRC_MAC    = 48'h00_0A_35_01_02_03,
  parameter mac_tx_pkg::mac_addr_t P_DST_MAC    = 48'hFF_FF_FF_FF_FF_FF,
  parameter int                    P_BUF_WORDS  = 256,
  parameter int                    P_DESC_DEPTH = 16
) (
  input  wire                       i_clk,
  input  wire                       i_rst,
  input  mac_tx_pkg::xgmii_word_t   i_tdata,
  input  mac_tx_pkg::byte_keep_t    i_tkeep,
  input  wire                       i_tlast,
  input  wire                       i_tvalid,
  input  mac_tx_pkg::eth_type_t     i_eth_type,
  output logic                      o_tready,
  output mac_tx_pkg::xgmii_word_t   o_xgmii_txd,
  output mac_tx_pkg::xgmii_ctrl_t   o_xgmii_txc
);
  import mac_tx_pkg::*;

  logic        desc_valid;
  word_count_t desc_words;
  byte_keep_t  desc_tail_keep;
  eth_type_t   desc_type;
  logic        desc_pop;
  logic        word_rd;
  xgmii_word_t buf_word;

  xgmii_word_t bld_word;
  xgmii_ctrl_t bld_ctrl;
  byte_keep_t  crc_keep;
  logic        crc_first;
  logic        bld_last;
  byte_keep_t  bld_tail_keep;

  crc_t        crc;
  logic        crc_done;

  tx_frame_buffer #(
    .P_BUF_WORDS  (P_BUF_WORDS),
    .P_DESC_DEPTH (P_DESC_DEPTH)
  ) u_buffer (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_tdata          (i_tdata),
    .i_tkeep          (i_tkeep),
    .i_tlast          (i_tlast),
    .i_tvalid         (i_tvalid),
    .i_eth_type       (i_eth_type),
    .o_tready         (o_tready),
    .i_desc_pop       (desc_pop),
    .i_word_rd        (word_rd),
    .o_desc_valid     (desc_valid),
    .o_desc_words     (desc_words),
    .o_desc_tail_keep (desc_tail_keep),
    .o_desc_type      (desc_type),
    .o_word           (buf_word)
  );

  tx_frame_builder #(
    .P_SRC_MAC (P_SRC_MAC),
    .P_DST_MAC (P_DST_MAC)
  ) u_builder (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_desc_valid     (desc_valid),
    .i_desc_words     (desc_words),
    .i_desc_tail_keep (desc_tail_keep),
    .i_desc_type      (desc_type),
    .o_desc_pop       (desc_pop),
    .o_word_rd        (word_rd),
    .i_word           (buf_word),
    .o_word           (bld_word),
    .o_ctrl           (bld_ctrl),
    .o_crc_keep       (crc_keep),
    .o_crc_first      (crc_first),
    .o_last           (bld_last),
    .o_tail_keep      (bld_tail_keep)
  );

  crc32_engine u_crc (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_word      (bld_word),
    .i_crc_keep  (crc_keep),
    .i_crc_first (crc_first),
    .o_crc       (crc),
    .o_crc_done  (crc_done)
  );

  xgmii_terminator u_term (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_word      (bld_word),
    .i_ctrl      (bld_ctrl),
    .i_last      (bld_last),
    .i_tail_keep (bld_tail_keep),
    .i_crc       (crc),
    .i_crc_done  (crc_done),
    .o_xgmii_txd (o_xgmii_txd),
    .o_xgmii_txc (o_xgmii_txc)
  );

endmodule

`default_nettype wire

//--- design/tx_frame_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module tx_frame_buffer #(
  parameter int P_BUF_WORDS  = 256,
  parameter int P_DESC_DEPTH = 16
) (
  input  wire                       i_clk,
  input  wire                       i_rst,
  input  mac_tx_pkg::xgmii_word_t   i_tdata,
  input  mac_tx_pkg::byte_keep_t    i_tkeep,
  input  wire                       i_tlast,
  input  wire                       i_tvalid,
  input  mac_tx_pkg::eth_type_t     i_eth_type,
  output logic                      o_tready,
  input  wire                       i_desc_pop,
  input  wire                       i_word_rd,
  output logic                      o_desc_valid,
  output mac_tx_pkg::word_count_t   o_desc_words,
  output mac_tx_pkg::byte_keep_t    o_desc_tail_keep,
  output mac_tx_pkg::eth_type_t     o_desc_type,
  output mac_tx_pkg::xgmii_word_t   o_word
);
  import mac_tx_pkg::*;

  localparam int AW = $clog2(P_BUF_WORDS);
  localparam int DW = $clog2(P_DESC_DEPTH);

  xgmii_word_t mem [P_BUF_WORDS];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   used;

  word_count_t desc_words_q [P_DESC_DEPTH];
  byte_keep_t  desc_keep_q  [P_DESC_DEPTH];
  eth_type_t   desc_type_q  [P_DESC_DEPTH];
  logic [DW-1:0] desc_wr;
  logic [DW-1:0] desc_rd;
  logic [DW:0]   desc_count;

  word_count_t cur_words;
  eth_type_t   cur_type;
  eth_type_t   frame_type;
  logic        in_frame;
  logic        ready_en;
  logic        wr_en;
  logic        push;

  assign o_tready = ready_en && (used != (AW+1)'(P_BUF_WORDS)) &&
                    (desc_count != (DW+1)'(P_DESC_DEPTH));
  assign wr_en = i_tvalid && o_tready;
  assign push  = wr_en && i_tlast;
  // Type is taken from the first beat, which may also be the last
  assign frame_type = in_frame ? cur_type : i_eth_type;

  assign o_desc_valid     = (desc_count != '0);
  assign o_desc_words     = desc_words_q[desc_rd];
  assign o_desc_tail_keep = desc_keep_q[desc_rd];
  assign o_desc_type      = desc_type_q[desc_rd];

  always_ff @(posedge i_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_tdata;
    end
    if (i_word_rd) begin
      o_word <= mem[rd_ptr];
    end
    if (push) begin
      desc_words_q[desc_wr] <= cur_words + 16'd1;
      desc_keep_q[desc_wr]  <= i_tkeep;
      desc_type_q[desc_wr]  <= frame_type;
    end
    if (wr_en && !in_frame) begin
      cur_type <= i_eth_type;
    end
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      used       <= '0;
      desc_wr    <= '0;
      desc_rd    <= '0;
      desc_count <= '0;
      cur_words  <= '0;
      in_frame   <= 1'b0;
      ready_en   <= 1'b0;
    end else begin
      ready_en <= 1'b1;
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_word_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      used <= used + (AW+1)'(wr_en) - (AW+1)'(i_word_rd);
      if (push) begin
        desc_wr <= desc_wr + 1'b1;
      end
      if (i_desc_pop) begin
        desc_rd <= desc_rd + 1'b1;
      end
      desc_count <= desc_count + (DW+1)'(push) - (DW+1)'(i_desc_pop);
      if (push) begin
        cur_words <= '0;
        in_frame  <= 1'b0;
      end else if (wr_en) begin
        cur_words <= cur_words + 16'd1;
        in_frame  <= 1'b1;
      end
    end
  end

  // Pointers meet only when the memory is empty or full
  a_no_write_full: assert property (@(posedge i_clk) disable iff (i_rst)
    wr_en |-> ((wr_ptr != rd_ptr) || (used == '0)));
  a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_rst)
    i_desc_pop |-> o_desc_valid);
  // Builder never reads past what was stored
  a_no_read_empty: assert property (@(posedge i_clk) disable iff (i_rst)
    i_word_rd |-> (used != '0));

endmodule

`default_nettype wire

//--- design/tx_frame_builder.sv
`timescale 1ns/10ps
`default_nettype none

module tx_frame_builder #(
  parameter mac_tx_pkg::mac_addr_t P_SRC_MAC = 48'h00_00_00_00_00_00,
  parameter mac_tx_pkg::mac_addr_t P_DST_MAC = 48'h00_00_00_00_00_00
) (
  input  wire                       i_clk,
  input  wire                       i_rst,
  input  wire                       i_desc_valid,
  input  mac_tx_pkg::word_count_t   i_desc_words,
  input  mac_tx_pkg::byte_keep_t    i_desc_tail_keep,
  input  mac_tx_pkg::eth_type_t     i_desc_type,
  output logic                      o_desc_pop,
  output logic                      o_word_rd,
  input  mac_tx_pkg::xgmii_word_t   i_word,
  output mac_tx_pkg::xgmii_word_t   o_word,
  output mac_tx_pkg::xgmii_ctrl_t   o_ctrl,
  output mac_tx_pkg::byte_keep_t    o_crc_keep,
  output logic                      o_crc_first,
  output logic                      o_last,
  output mac_tx_pkg::byte_keep_t    o_tail_keep
);
  import mac_tx_pkg::*;

  builder_state_t state;
  word_count_t    words;
  word_count_t    idx;
  byte_keep_t     tail_keep;
  eth_type_t      eth_type;
  xgmii_word_t    prev;
  logic [1:0]     gap_cnt;
  logic           single_byte_tail;
  logic           more_words;

  // Tail of one byte leaves nothing for an extra shifted word
  assign single_byte_tail = (tail_keep == 8'h80);
  assign more_words = (word_count_t'(idx + 16'd1) < words);

  assign o_desc_pop = (state == IDLE) && i_desc_valid;
  assign o_word_rd  = (state == PREAMBLE) ||
                      ((state == HEADER_B) && (words > 16'd1)) ||
                      ((state == PAYLOAD) && more_words);

  always_ff @(posedge i_clk) begin
    if (o_desc_pop) begin
      words     <= i_desc_words;
      tail_keep <= i_desc_tail_keep;
      eth_type  <= i_desc_type;
    end
    if (state == HEADER_B || state == PAYLOAD) begin
      prev <= i_word;
    end
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      state       <= IDLE;
      idx         <= '0;
      gap_cnt     <= '0;
      o_word      <= {8{XGMII_IDLE}};
      o_ctrl      <= 8'hFF;
      o_crc_keep  <= '0;
      o_crc_first <= 1'b0;
      o_last      <= 1'b0;
      o_tail_keep <= '0;
    end else begin
      o_word      <= {8{XGMII_IDLE}};
      o_ctrl      <= 8'hFF;
      o_crc_keep  <= '0;
      o_crc_first <= 1'b0;
      o_last      <= 1'b0;
      o_tail_keep <= '0;
      case (state)
        IDLE: begin
          if (i_desc_valid) begin
            state <= PREAMBLE;
          end
        end
        PREAMBLE: begin
          o_word <= {XGMII_START, {7{PREAMBLE_BYTE}}};
          o_ctrl <= 8'h80;
          state  <= HEADER_A;
        end
        HEADER_A: begin
          o_word      <= {SFD_BYTE, P_DST_MAC, P_SRC_MAC[47:40]};
          o_ctrl      <= 8'h00;
          o_crc_keep  <= 8'h7F;
          o_crc_first <= 1'b1;
          state       <= HEADER_B;
        end
        HEADER_B: begin
          o_word     <= {P_SRC_MAC[39:0], eth_type, i_word[63:56]};
          o_ctrl     <= 8'h00;
          o_crc_keep <= 8'hFF;
          idx        <= 16'd1;
          if (words == 16'd1 && single_byte_tail) begin
            o_last      <= 1'b1;
            o_tail_keep <= 8'hFF;
            state       <= GAP;
          end else if (words == 16'd1) begin
            state <= TAIL;
          end else begin
            state <= PAYLOAD;
          end
        end
        PAYLOAD: begin
          o_word     <= {prev[55:0], i_word[63:56]};
          o_ctrl     <= 8'h00;
          o_crc_keep <= 8'hFF;
          idx        <= idx + 16'd1;
          if (!more_words && single_byte_tail) begin
            o_last      <= 1'b1;
            o_tail_keep <= 8'hFF;
            state       <= GAP;
          end else if (!more_words) begin
            state <= TAIL;
          end
        end
        TAIL: begin
          // Bytes 1..7 of the last stored word, one lane earlier
          o_word      <= {prev[55:0], 8'h00};
          o_ctrl      <= 8'h00;
          o_crc_keep  <= tail_keep << 1;
          o_last      <= 1'b1;
          o_tail_keep <= tail_keep << 1;
          state       <= GAP;
        end
        GAP: begin
          gap_cnt <= gap_cnt + 2'd1;
          if (gap_cnt == 2'(GAP_WORDS - 1)) begin
            gap_cnt <= '0;
            state   <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  a_keep_contiguous: assert property (@(posedge i_clk) disable iff (i_rst)
    ((o_crc_keep + (o_crc_keep & (~o_crc_keep + 8'd1))) & o_crc_keep) == 8'h00);

endmodule

`default_nettype wire

//--- design/xgmii_terminator.sv
`timescale 1ns/10ps
`default_nettype none

module xgmii_terminator (
  input  wire                       i_clk,
  input  wire                       i_rst,
  input  mac_tx_pkg::xgmii_word_t   i_word,
  input  mac_tx_pkg::xgmii_ctrl_t   i_ctrl,
  input  wire                       i_last,
  input  mac_tx_pkg::byte_keep_t    i_tail_keep,
  input  mac_tx_pkg::crc_t          i_crc,
  input  wire                       i_crc_done,
  output mac_tx_pkg::xgmii_word_t   o_xgmii_txd,
  output mac_tx_pkg::xgmii_ctrl_t   o_xgmii_txc
);
  import mac_tx_pkg::*;

  xgmii_word_t s1_word;
  xgmii_ctrl_t s1_ctrl;
  logic        s1_last;
  byte_keep_t  s1_keep;

  xgmii_word_t spill_word;
  xgmii_ctrl_t spill_ctrl;
  logic        spill_pending;

  logic [127:0] ext_word;
  logic [15:0]  ext_ctrl;
  logic [3:0]   n_data;

  ////////////////////////////////
  // Two words of lanes after the last frame byte
  ////////////////////////////////
  always_comb begin
    n_data   = 4'($countones(s1_keep));
    ext_word = {s1_word, {8{XGMII_IDLE}}};
    ext_ctrl = 16'h0000;
    for (int i = 0; i < 16; i++) begin
      if (i >= n_data + 4) begin
        ext_ctrl[15-i]       = 1'b1;
        ext_word[127-8*i -: 8] = (i == n_data + 4) ? XGMII_TERM : XGMII_IDLE;
      end else if (i >= n_data) begin
        // FCS goes out low byte first
        ext_word[127-8*i -: 8] = i_crc[8*(i-n_data) +: 8];
      end
    end
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      s1_word       <= {8{XGMII_IDLE}};
      s1_ctrl       <= 8'hFF;
      s1_last       <= 1'b0;
      s1_keep       <= '0;
      spill_word    <= {8{XGMII_IDLE}};
      spill_ctrl    <= 8'hFF;
      spill_pending <= 1'b0;
      o_xgmii_txd   <= {8{XGMII_IDLE}};
      o_xgmii_txc   <= 8'hFF;
    end else begin
      s1_word <= i_word;
      s1_ctrl <= i_ctrl;
      s1_last <= i_last;
      s1_keep <= i_tail_keep;
      spill_pending <= 1'b0;
      if (s1_last && i_crc_done) begin
        o_xgmii_txd   <= ext_word[127:64];
        o_xgmii_txc   <= ext_ctrl[15:8];
        spill_word    <= ext_word[63:0];
        spill_ctrl    <= ext_ctrl[7:0];
        spill_pending <= 1'b1;
      end else if (spill_pending) begin
        // Overwrites the first gap word
        o_xgmii_txd <= spill_word;
        o_xgmii_txc <= spill_ctrl;
      end else begin
        o_xgmii_txd <= s1_word;
        o_xgmii_txc <= s1_ctrl;
      end
    end
  end

  function automatic logic ctrl_lanes_ok(xgmii_word_t txd, xgmii_ctrl_t txc);
    logic ok;
    logic [7:0] b;
    ok = 1'b1;
    for (int i = 0; i < 8; i++) begin
      b = txd[8*i +: 8];
      if (txc[i] && b != XGMII_IDLE && b != XGMII_START && b != XGMII_TERM) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  a_ctrl_lanes: assert property (@(posedge i_clk) disable iff (i_rst)
    ctrl_lanes_ok(o_xgmii_txd, o_xgmii_txc));

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mac_tx -f tb.f -o sim_mac_tx
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_mac_tx > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Test passed" sim.log; then
  exit 0
fi
exit 1

//--- tb.f
common/mac_tx_pkg.sv
crc/crc32_byte_lane.sv
crc/crc32_engine.sv
design/tx_frame_buffer.sv
design/tx_frame_builder.sv
design/xgmii_terminator.sv
design/ten_gig_mac_tx.sv
tb/tb_mac_tx.sv

//--- tb/tb_mac_tx.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mac_tx;
  import mac_tx_pkg::*;

  localparam mac_addr_t SRC_MAC = 48'h02_1A_2B_3C_4D_5E;
  localparam mac_addr_t DST_MAC = 48'h00_11_22_33_44_55;
  localparam int FRAME_WAIT = 4000;
  localparam int B2B_LEN [5] = '{46, 64, 47, 100, 53};

  logic        i_clk;
  logic        i_rst;
  xgmii_word_t i_tdata;
  byte_keep_t  i_tkeep;
  logic        i_tlast;
  logic        i_tvalid;
  eth_type_t   i_eth_type;
  logic        o_tready;
  xgmii_word_t o_xgmii_txd;
  xgmii_ctrl_t o_xgmii_txc;

  logic [31:0] rng;
  int          rand_len [10];
  int          limit_cycles;
  string       test_name;
  int          checks;
  int          errors;
  int          tests_run;
  int          test_checks0;
  int          test_errors0;

  logic [7:0]  tx_pay [$];
  logic [7:0]  exp_q [$];
  int          exp_len_q [$];
  crc_t        exp_crc_q [$];
  logic [7:0]  rx_q [$];
  int          rx_len_q [$];
  logic        in_frame;
  logic        idle_seen;
  int          cur_len;
  int          rx_seen;

  ten_gig_mac_tx #(
    .P_SRC_MAC    (SRC_MAC),
    .P_DST_MAC    (DST_MAC),
    .P_BUF_WORDS  (256),
    .P_DESC_DEPTH (16)
  ) dut (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_tdata     (i_tdata),
    .i_tkeep     (i_tkeep),
    .i_tlast     (i_tlast),
    .i_tvalid    (i_tvalid),
    .i_eth_type  (i_eth_type),
    .o_tready    (o_tready),
    .o_xgmii_txd (o_xgmii_txd),
    .o_xgmii_txc (o_xgmii_txc)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Bit at a time, LSB of each byte first
  function automatic crc_t crc_ref_byte(input crc_t c, input logic [7:0] b);
    crc_t r;
    logic fb;
    r = c;
    for (int i = 0; i < 8; i++) begin
      fb = r[0] ^ b[i];
      r = r >> 1;
      if (fb) begin
        r = r ^ 32'hEDB8_8320;
      end
    end
    return r;
  endfunction

  function automatic int frame_cycles(input int len);
    return ((len + 7) / 8 + 4) * 4;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("FAIL %s: %s", test_name, msg);
  endtask

  task automatic compare_word(input xgmii_word_t expected, input xgmii_word_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR %s expected %h actual %h", test_name, expected, actual);
    end
  endtask

  task automatic compare_ctrl(input xgmii_ctrl_t expected, input xgmii_ctrl_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR %s expected %h actual %h", test_name, expected, actual);
    end
  endtask

  task automatic compare_crc(input crc_t expected, input crc_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR %s expected %h actual %h", test_name, expected, actual);
    end
  endtask

  //////////////////////////////
  // XGMII monitor
  //////////////////////////////
  task automatic monitor_word(input xgmii_word_t txd, input xgmii_ctrl_t txc);
    int top;
    logic ended;
    logic [7:0] b;
    top = 7;
    ended = 1'b0;
    if (!in_frame) begin
      if (txc[7] && txd[63:56] == 8'hFB) begin
        if (rx_seen > 0 && !idle_seen) begin
          report_error("frame started with no idle word after the previous one");
        end
        in_frame = 1'b1;
        cur_len = 0;
        top = 6;
      end else if (txd == 64'h0707_0707_0707_0707 && txc == 8'hFF) begin
        idle_seen = 1'b1;
        return;
      end else begin
        report_error($sformatf("stray word %h ctrl %h between frames", txd, txc));
        return;
      end
    end
    for (int l = top; l >= 0; l--) begin
      b = txd[8*l +: 8];
      if (ended) begin
        if (!txc[l] || b != 8'h07) begin
          report_error("lane after the terminate character is not idle");
        end
      end else if (!txc[l]) begin
        rx_q.push_back(b);
        cur_len++;
      end else if (b == 8'hFD) begin
        ended = 1'b1;
        in_frame = 1'b0;
        idle_seen = 1'b0;
        rx_len_q.push_back(cur_len);
        rx_seen++;
      end else begin
        report_error($sformatf("control byte %h inside a frame", b));
      end
    end
  endtask

  always @(negedge i_clk) begin
    if (!i_rst) begin
      monitor_word(o_xgmii_txd, o_xgmii_txc);
    end
  end

  //////////////////////////////
  // Stimulus and checking
  //////////////////////////////
  // Wire bytes from the preamble up to the FCS, and the FCS itself
  task automatic expect_frame(input eth_type_t etype);
    logic [7:0] body [$];
    crc_t crc;
    for (int i = 0; i < 7; i++) begin
      body.push_back(8'h55);
    end
    body.push_back(8'hD5);
    for (int i = 5; i >= 0; i--) begin
      body.push_back(DST_MAC[8*i +: 8]);
    end
    for (int i = 5; i >= 0; i--) begin
      body.push_back(SRC_MAC[8*i +: 8]);
    end
    body.push_back(etype[15:8]);
    body.push_back(etype[7:0]);
    foreach (tx_pay[i]) begin
      body.push_back(tx_pay[i]);
    end
    crc = 32'hFFFF_FFFF;
    for (int i = 8; i < body.size(); i++) begin
      crc = crc_ref_byte(crc, body[i]);
    end
    exp_crc_q.push_back(crc ^ 32'hFFFF_FFFF);
    exp_len_q.push_back(body.size() + 4);
    foreach (body[i]) begin
      exp_q.push_back(body[i]);
    end
  endtask

  task automatic send_frame(input int n_bytes, input eth_type_t etype);
    xgmii_word_t w;
    byte_keep_t k;
    int n_words;
    logic accepted;
    tx_pay.delete();
    for (int i = 0; i < n_bytes; i++) begin
      rng = xorshift32(rng);
      tx_pay.push_back(rng[7:0]);
    end
    expect_frame(etype);
    n_words = (n_bytes + 7) / 8;
    for (int wi = 0; wi < n_words; wi++) begin
      w = '0;
      k = '0;
      for (int j = 0; j < 8; j++) begin
        if (wi * 8 + j < n_bytes) begin
          w[63-8*j -: 8] = tx_pay[wi*8+j];
          k[7-j] = 1'b1;
        end
      end
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge i_clk);
        i_tdata    = w;
        i_tkeep    = k;
        i_tlast    = (wi == n_words - 1);
        i_tvalid   = 1'b1;
        // Only the first beat carries the frame type
        i_eth_type = (wi == 0) ? etype : ~etype;
        accepted   = o_tready;
        @(posedge i_clk);
      end
    end
  endtask

  task automatic stop_input();
    @(negedge i_clk);
    i_tvalid = 1'b0;
    i_tlast  = 1'b0;
  endtask

  task automatic check_frames(input int n);
    int waited;
    int rlen;
    int elen;
    xgmii_word_t ew;
    xgmii_word_t aw;
    logic [7:0] rb [$];
    waited = 0;
    while (rx_len_q.size() < n && waited < FRAME_WAIT) begin
      @(posedge i_clk);
      waited++;
    end
    if (rx_len_q.size() < n) begin
      report_error($sformatf("only %0d of %0d frames came out", rx_len_q.size(), n));
      n = rx_len_q.size();
    end
    for (int f = 0; f < n; f++) begin
      rlen = rx_len_q.pop_front();
      elen = exp_len_q.pop_front();
      rb.delete();
      for (int i = 0; i < rlen; i++) begin
        rb.push_back(rx_q.pop_front());
      end
      if (rlen != elen) begin
        report_error($sformatf("frame %0d has %0d bytes instead of %0d", f, rlen, elen));
        for (int i = 0; i < elen - 4; i++) begin
          void'(exp_q.pop_front());
        end
        void'(exp_crc_q.pop_front());
        continue;
      end
      for (int i = 0; i < elen - 4; i += 8) begin
        ew = '0;
        aw = '0;
        for (int j = 0; j < 8; j++) begin
          if (i + j < elen - 4) begin
            ew[63-8*j -: 8] = exp_q.pop_front();
            aw[63-8*j -: 8] = rb[i+j];
          end
        end
        compare_word(ew, aw);
      end
      // FCS arrives low byte first
      compare_crc(exp_crc_q.pop_front(), {rb[rlen-1], rb[rlen-2], rb[rlen-3], rb[rlen-4]});
    end
    exp_q.delete();
    exp_len_q.delete();
    exp_crc_q.delete();
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_checks0 = checks;
    test_errors0 = errors;
  endtask

  task automatic end_test();
    if (rx_len_q.size() != 0) begin
      report_error("an unexpected extra frame came out");
      rx_len_q.delete();
      rx_q.delete();
    end
    tests_run++;
    $display("%-18s %0d checks, %0d errors", test_name, checks - test_checks0,
             errors - test_errors0);
  endtask

  task automatic apply_reset();
    test_name = "reset";
    repeat (8) @(posedge i_clk);
    @(negedge i_clk);
    if (o_tready) begin
      report_error("o_tready is high during reset");
    end
    i_rst = 1'b0;
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////
  task automatic test_idle_after_reset();
    begin_test("idle_after_reset");
    repeat (4) begin
      @(negedge i_clk);
      compare_word(64'h0707_0707_0707_0707, o_xgmii_txd);
      compare_ctrl(8'hFF, o_xgmii_txc);
    end
    end_test();
  endtask

  task automatic test_single_frame();
    begin_test("single_frame");
    send_frame(64, 16'h0800);
    stop_input();
    check_frames(1);
    end_test();
  endtask

  // Last word keeps 1 to 8 bytes, so the FCS spills in some cases
  task automatic test_tail_keep_sweep();
    begin_test("tail_keep_sweep");
    for (int k = 1; k <= 8; k++) begin
      send_frame(48 + k, eth_type_t'(16'h88B5 + k));
      stop_input();
      check_frames(1);
    end
    end_test();
  endtask

  task automatic test_back_to_back();
    begin_test("back_to_back");
    for (int i = 0; i < 5; i++) begin
      send_frame(B2B_LEN[i], eth_type_t'(16'h0900 + i));
    end
    stop_input();
    check_frames(5);
    end_test();
  endtask

  task automatic test_random_stream();
    begin_test("random_stream");
    for (int i = 0; i < 10; i++) begin
      send_frame(rand_len[i], eth_type_t'(rng[15:0]));
    end
    stop_input();
    check_frames(10);
    end_test();
  endtask

  initial begin
    i_rst      = 1'b1;
    i_tdata    = '0;
    i_tkeep    = '0;
    i_tlast    = 1'b0;
    i_tvalid   = 1'b0;
    i_eth_type = '0;
    in_frame   = 1'b0;
    idle_seen  = 1'b0;
    cur_len    = 0;
    rx_seen    = 0;
    checks     = 0;
    errors     = 0;
    tests_run  = 0;
    rng        = 32'hff7d8378;
    for (int i = 0; i < 10; i++) begin
      rng = xorshift32(rng);
      rand_len[i] = 46 + int'(rng % 32'd255);
    end
    limit_cycles = 200 + frame_cycles(64);
    for (int k = 1; k <= 8; k++) begin
      limit_cycles += frame_cycles(48 + k);
    end
    for (int i = 0; i < 5; i++) begin
      limit_cycles += frame_cycles(B2B_LEN[i]);
    end
    for (int i = 0; i < 10; i++) begin
      limit_cycles += frame_cycles(rand_len[i]);
    end
    apply_reset();
    test_idle_after_reset();
    test_single_frame();
    test_tail_keep_sweep();
    test_back_to_back();
    test_random_stream();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge i_clk);
    $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire
